//--- build.f
dcache_pkg.sv
mem_req_if.sv
ldst_lanes.sv
dcache_ctrl.sv
wb_bridge.sv
dcache_top.sv
tb_clock.sv
tb_wb_mem.sv
tb_dcache_asserts.sv
tb_dcache.sv

//--- dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter int index_bits = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_cyc,
    input  logic              cpu_stb,
    input  logic              cpu_we,
    input  dcache_pkg::addr_t cpu_adr,
    input  logic [2:0]        cpu_op,
    output dcache_pkg::data_t cpu_dat_r,
    output logic              cpu_ack,
    output dcache_pkg::data_t lane_old_word,
    input  dcache_pkg::data_t lane_load,
    input  dcache_pkg::data_t lane_store,
    input  dcache_pkg::sel_t  lane_sel,
    mem_req_if.ctrl           mem
);

    localparam int lines    = 1 << index_bits;
    localparam int tag_bits = dcache_pkg::cached_bits - index_bits - 2;

    typedef logic [index_bits-1:0] index_t;
    typedef logic [tag_bits-1:0]   tag_t;

    dcache_pkg::ctrl_state_e state;

    logic [lines-1:0]  valid_q;
    logic [lines-1:0]  dirty_q;
    tag_t              tag_arr  [lines];
    dcache_pkg::data_t data_arr [lines];

    index_t index;
    tag_t   tag;
    logic   access;
    logic   uncached;
    logic   store_op;
    logic   hit;
    logic   fill_done;
    logic   ack_store;

    assign index    = cpu_adr[index_bits+1:2];
    assign tag      = cpu_adr[dcache_pkg::cached_bits-1:index_bits+2];
    assign access   = cpu_cyc && cpu_stb;
    assign uncached = cpu_adr[dcache_pkg::mmio_lsb +: 4] == dcache_pkg::mmio_region;
    assign store_op = dcache_pkg::is_store(dcache_pkg::ldst_op_e'(cpu_op));
    assign hit      = valid_q[index] && (tag_arr[index] == tag);

    assign fill_done = (state == dcache_pkg::st_fill) && mem.done;
    assign ack_store = (state == dcache_pkg::st_ack) && store_op && !uncached;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::st_idle;
        end else begin
            case (state)
                dcache_pkg::st_idle: begin
                    if (access) begin
                        if (uncached)
                            state <= dcache_pkg::st_io;
                        else if (hit)
                            state <= dcache_pkg::st_ack;
                        else if (valid_q[index] && dirty_q[index])
                            state <= dcache_pkg::st_wback;
                        else
                            state <= dcache_pkg::st_fill;
                    end
                end
                dcache_pkg::st_wback: begin
                    if (mem.done) state <= dcache_pkg::st_fill;
                end
                dcache_pkg::st_fill, dcache_pkg::st_io: begin
                    if (mem.done) state <= dcache_pkg::st_ack;
                end
                default: state <= dcache_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_done) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= store_op;
        end else if (ack_store) begin
            dirty_q[index] <= 1'b1;
        end
    end

    // a store miss merges straight into the refill word
    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_arr[index]  <= tag;
            data_arr[index] <= store_op ? lane_store : mem.rdata;
        end else if (ack_store) begin
            data_arr[index] <= lane_store;
        end
    end

    always_comb begin
        if (uncached)
            lane_old_word = store_op ? '0 : mem.rdata;
        else if (state == dcache_pkg::st_fill)
            lane_old_word = mem.rdata;
        else
            lane_old_word = data_arr[index];
    end

    assign mem.req = state inside {dcache_pkg::st_wback, dcache_pkg::st_fill, dcache_pkg::st_io};

    always_comb begin
        mem.we    = 1'b0;
        mem.adr   = dcache_pkg::addr_t'({tag, index, 2'b00});
        mem.sel   = '1;
        mem.wdata = data_arr[index];
        case (state)
            dcache_pkg::st_wback: begin
                // victim goes back to its own address
                mem.we  = 1'b1;
                mem.adr = dcache_pkg::addr_t'({tag_arr[index], index, 2'b00});
            end
            dcache_pkg::st_io: begin
                mem.we    = cpu_we;
                mem.adr   = {cpu_adr[31:2], 2'b00};
                mem.sel   = lane_sel;
                mem.wdata = lane_store;
            end
            default: ;
        endcase
    end

    assign cpu_ack   = state == dcache_pkg::st_ack;
    assign cpu_dat_r = lane_load;

endmodule

`default_nettype wire

//--- dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int data_w = 32;
    localparam int addr_w = 32;
    localparam int sel_w  = data_w / 8;

    // cached space is the low 64 KiB
    localparam int cached_bits = 16;

    // mmio window selected by address bits 19..16
    localparam int              mmio_lsb    = 16;
    localparam logic [3:0]      mmio_region = 4'hf;

    typedef logic [data_w-1:0] data_t;
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [sel_w-1:0]  sel_t;

    typedef enum logic [2:0] {
        op_lw  = 3'd0,
        op_lh  = 3'd1,
        op_lhu = 3'd2,
        op_lb  = 3'd3,
        op_lbu = 3'd4,
        op_sw  = 3'd5,
        op_sh  = 3'd6,
        op_sb  = 3'd7
    } ldst_op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_wback,
        st_fill,
        st_io,
        st_ack
    } ctrl_state_e;

    function automatic logic is_store(ldst_op_e op);
        return op inside {op_sw, op_sh, op_sb};
    endfunction

endpackage

`default_nettype wire

//--- dcache_stim.txt
# op(0 lw 1 lh 2 lhu 3 lb 4 lbu 5 sw 6 sh 7 sb) address wdata expected_load mem_cycles
# memory word at byte address a holds {a ^ f0f0, a}, mmio register starts at 12345678
0 00000100 00000000 f1f00100 1
0 00000100 00000000 f1f00100 0
3 00000102 00000000 fffffff0 0
4 00000102 00000000 000000f0 0
1 00000102 00000000 fffff1f0 0
2 00000102 00000000 0000f1f0 0
3 00000101 00000000 00000001 0
1 00000100 00000000 00000100 0
7 00000103 000000aa 00000000 0
6 00000100 0000beef 00000000 0
0 00000100 00000000 aaf0beef 0
0 00000500 00000000 f5f00500 2
0 00000100 00000000 aaf0beef 1
7 00000205 00000077 00000000 1
0 00000204 00000000 f2f47704 0
0 00000604 00000000 f6f40604 2
2 00000206 00000000 0000f2f4 1
0 00010604 00000000 f6f40604 1
1 00000606 00000000 fffff6f4 0
0 000f0010 00000000 12345678 1
7 000f0012 000000c3 00000000 1
6 000f0010 0000a55a 00000000 1
0 000f0010 00000000 12c3a55a 1
3 000f0011 00000000 ffffffa5 1
5 000f0010 deadbeef 00000000 1
4 000f0013 00000000 000000de 1

//--- dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int index_bits = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_cyc,
    input  logic              cpu_stb,
    input  logic              cpu_we,
    input  dcache_pkg::addr_t cpu_adr,
    input  logic [2:0]        cpu_op,
    input  dcache_pkg::data_t cpu_dat_w,
    output dcache_pkg::data_t cpu_dat_r,
    output logic              cpu_ack,
    output logic              mem_cyc,
    output logic              mem_stb,
    output logic              mem_we,
    output dcache_pkg::addr_t mem_adr,
    output dcache_pkg::sel_t  mem_sel,
    output dcache_pkg::data_t mem_dat_w,
    input  dcache_pkg::data_t mem_dat_r,
    input  logic              mem_ack
);

    dcache_pkg::data_t old_word;
    dcache_pkg::data_t load_data;
    dcache_pkg::data_t merged;
    dcache_pkg::sel_t  sel;

    mem_req_if u_mem_req ();

    dcache_ctrl #(
        .index_bits(index_bits)
    ) u_dcache_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_cyc      (cpu_cyc),
        .cpu_stb      (cpu_stb),
        .cpu_we       (cpu_we),
        .cpu_adr      (cpu_adr),
        .cpu_op       (cpu_op),
        .cpu_dat_r    (cpu_dat_r),
        .cpu_ack      (cpu_ack),
        .lane_old_word(old_word),
        .lane_load    (load_data),
        .lane_store   (merged),
        .lane_sel     (sel),
        .mem          (u_mem_req)
    );

    ldst_lanes u_ldst_lanes (
        .op        (cpu_op),
        .byte_off  (cpu_adr[1:0]),
        .old_word  (old_word),
        .store_data(cpu_dat_w),
        .load_data (load_data),
        .merged    (merged),
        .sel       (sel)
    );

    wb_bridge u_wb_bridge (
        .clk      (clk),
        .rst      (rst),
        .req      (u_mem_req),
        .mem_cyc  (mem_cyc),
        .mem_stb  (mem_stb),
        .mem_we   (mem_we),
        .mem_adr  (mem_adr),
        .mem_sel  (mem_sel),
        .mem_dat_w(mem_dat_w),
        .mem_dat_r(mem_dat_r),
        .mem_ack  (mem_ack)
    );

endmodule

`default_nettype wire

//--- ldst_lanes.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_lanes (
    input  logic [2:0]        op,
    input  logic [1:0]        byte_off,
    input  dcache_pkg::data_t old_word,
    input  dcache_pkg::data_t store_data,
    output dcache_pkg::data_t load_data,
    output dcache_pkg::data_t merged,
    output dcache_pkg::sel_t  sel
);

    dcache_pkg::ldst_op_e op_e;
    dcache_pkg::data_t    lane_data;
    logic [15:0]          half;
    logic [7:0]           byte_v;
    logic                 write;

    assign op_e   = dcache_pkg::ldst_op_e'(op);
    assign write  = dcache_pkg::is_store(op_e);
    assign half   = byte_off[1] ? old_word[31:16] : old_word[15:0];
    assign byte_v = old_word[{byte_off, 3'b000} +: 8];

    // load extraction
    always_comb begin
        case (op_e)
            dcache_pkg::op_lh:  load_data = {{16{half[15]}}, half};
            dcache_pkg::op_lhu: load_data = {16'h0000, half};
            dcache_pkg::op_lb:  load_data = {{24{byte_v[7]}}, byte_v};
            dcache_pkg::op_lbu: load_data = {24'h000000, byte_v};
            default:            load_data = old_word;
        endcase
    end

    // byte selects, all lanes for loads and full words
    always_comb begin
        case (op_e)
            dcache_pkg::op_sh: sel = byte_off[1] ? 4'b1100 : 4'b0011;
            dcache_pkg::op_sb: sel = dcache_pkg::sel_t'(4'b0001 << byte_off);
            default:           sel = 4'b1111;
        endcase
    end

    // replicate low bytes so every lane sees the store value
    always_comb begin
        case (op_e)
            dcache_pkg::op_sb: lane_data = {4{store_data[7:0]}};
            dcache_pkg::op_sh: lane_data = {2{store_data[15:0]}};
            default:           lane_data = store_data;
        endcase
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = (write && sel[i]) ? lane_data[8*i +: 8] : old_word[8*i +: 8];
        end
    end

endmodule

`default_nettype wire

//--- mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// single-word request channel from the cache controller to the bus bridge
interface mem_req_if;

    logic              req;
    logic              we;
    dcache_pkg::addr_t adr;
    dcache_pkg::sel_t  sel;
    dcache_pkg::data_t wdata;
    dcache_pkg::data_t rdata;
    logic              done;

    modport ctrl (
        output req, we, adr, sel, wdata,
        input  rdata, done
    );

    modport bridge (
        input  req, we, adr, sel, wdata,
        output rdata, done
    );

endinterface

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_dcache -o sim_dcache

out=$(./obj_dir/sim_dcache)
echo "$out"
echo "$out" | grep -q "Everything OK"

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for five rising edges
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    localparam int ack_timeout = 200;

    logic              clk;
    logic              rst;
    logic              cpu_cyc;
    logic              cpu_stb;
    logic              cpu_we;
    dcache_pkg::addr_t cpu_adr;
    logic [2:0]        cpu_op;
    dcache_pkg::data_t cpu_dat_w;
    dcache_pkg::data_t cpu_dat_r;
    logic              cpu_ack;
    logic              mem_cyc;
    logic              mem_stb;
    logic              mem_we;
    dcache_pkg::addr_t mem_adr;
    dcache_pkg::sel_t  mem_sel;
    dcache_pkg::data_t mem_dat_w;
    dcache_pkg::data_t mem_dat_r;
    logic              mem_ack;
    dcache_pkg::addr_t last_adr;
    logic              last_we;
    dcache_pkg::sel_t  last_sel;
    dcache_pkg::data_t last_dat_w;
    int                mem_cycles;

    tb_clock u_clock (.clk(clk), .rst(rst));

    dcache_top u_dcache_top (
        .clk(clk), .rst(rst),
        .cpu_cyc(cpu_cyc), .cpu_stb(cpu_stb), .cpu_we(cpu_we), .cpu_adr(cpu_adr),
        .cpu_op(cpu_op), .cpu_dat_w(cpu_dat_w), .cpu_dat_r(cpu_dat_r), .cpu_ack(cpu_ack),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr),
        .mem_sel(mem_sel), .mem_dat_w(mem_dat_w), .mem_dat_r(mem_dat_r), .mem_ack(mem_ack)
    );

    tb_wb_mem u_mem (
        .clk(clk), .rst(rst), .cyc(mem_cyc), .stb(mem_stb), .we(mem_we), .adr(mem_adr),
        .sel(mem_sel), .dat_w(mem_dat_w), .dat_r(mem_dat_r), .ack(mem_ack),
        .last_adr(last_adr), .last_we(last_we), .last_sel(last_sel), .last_dat_w(last_dat_w)
    );

    always @(posedge clk) begin
        if (rst) mem_cycles <= 0;
        else if (mem_cyc && mem_stb && mem_ack) mem_cycles <= mem_cycles + 1;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compare_word(input string what, input dcache_pkg::data_t actual,
                                input dcache_pkg::data_t expected);
        if (actual !== expected)
            stop_on_error($sformatf("FAILED at %0t: %s is %h, expected %h",
                                    $time, what, actual, expected));
    endtask

    // lanes written by a store, from its width and the byte offset
    function automatic dcache_pkg::sel_t expected_sel(input logic [2:0] op,
                                                      input logic [1:0] off);
        int nbytes;
        case (op)
            dcache_pkg::op_sb: nbytes = 1;
            dcache_pkg::op_sh: nbytes = 2;
            default:           nbytes = 4;
        endcase
        return dcache_pkg::sel_t'(((1 << nbytes) - 1) << off);
    endfunction

    task automatic run_access(input logic [2:0] op, input dcache_pkg::addr_t adr,
                              input dcache_pkg::data_t wdata,
                              output dcache_pkg::data_t rdata, output int lat,
                              output int cycles);
        int start;
        @(posedge clk);
        cpu_cyc   <= 1'b1;
        cpu_stb   <= 1'b1;
        cpu_we    <= op >= 3'd5;
        cpu_adr   <= adr;
        cpu_op    <= op;
        cpu_dat_w <= wdata;
        start = mem_cycles;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            if (lat > ack_timeout)
                stop_on_error($sformatf("no cpu_ack for access to %h", adr));
        end while (!cpu_ack);
        rdata  = cpu_dat_r;
        cycles = mem_cycles - start;
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
        cpu_we  <= 1'b0;
    endtask

    initial begin
        int                fd;
        int                n;
        int                lat;
        int                cycles;
        int                exp_cycles;
        string             line;
        logic [2:0]        op;
        dcache_pkg::addr_t adr;
        dcache_pkg::data_t wdata;
        dcache_pkg::data_t exp_data;
        dcache_pkg::data_t rdata;
        dcache_pkg::data_t mask;
        dcache_pkg::sel_t  sel_exp;
        logic              mmio;

        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_we    = 1'b0;
        cpu_adr   = '0;
        cpu_op    = 3'd0;
        cpu_dat_w = '0;

        fd = $fopen("dcache_stim.txt", "r");
        if (fd == 0) stop_on_error("cannot open stimulus file dcache_stim.txt");

        n = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            n++;
            if (n > 50) stop_on_error("reset was never released");
        end

        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() == 0 || line.substr(0, 0) == "#") continue;
            if ($sscanf(line, "%h %h %h %h %d", op, adr, wdata, exp_data, exp_cycles) != 5)
                continue;
            run_access(op, adr, wdata, rdata, lat, cycles);
            mmio = adr[19:16] == dcache_pkg::mmio_region;

            if (op < 3'd5) compare_word($sformatf("load data from %h", adr), rdata, exp_data);
            compare_word($sformatf("memory cycles for %h", adr), cycles, exp_cycles);
            if (exp_cycles == 0) compare_word("hit latency", lat, 2);

            if (mmio) compare_word("mmio address", last_adr, {adr[31:2], 2'b00});
            if (mmio && op >= 3'd5) begin
                sel_exp = expected_sel(op, adr[1:0]);
                for (int b = 0; b < 4; b++) mask[8*b +: 8] = {8{sel_exp[b]}};
                compare_word("mmio mem_sel", 32'(last_sel), 32'(sel_exp));
                compare_word("mmio lane data", last_dat_w & mask,
                             (wdata << {adr[1:0], 3'b000}) & mask);
                compare_word("mmio write enable", 32'(last_we), 32'd1);
            end else if (mmio) begin
                compare_word("mmio write enable", 32'(last_we), 32'd0);
            end else if (cycles > 0) begin
                // the last cycle of a miss is the refill read
                compare_word("refill address", last_adr, {16'h0000, adr[15:2], 2'b00});
                compare_word("refill write enable", 32'(last_we), 32'd0);
            end
        end
        $fclose(fd);

        // let the assertions of the last access settle
        @(posedge clk);
        if (u_dcache_top.u_dcache_asserts.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_on_error("a bus protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

//--- tb_dcache_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_asserts (
    input logic              clk,
    input logic              rst,
    input logic              cpu_cyc,
    input logic              cpu_stb,
    input logic              cpu_we,
    input dcache_pkg::addr_t cpu_adr,
    input logic [2:0]        cpu_op,
    input dcache_pkg::data_t cpu_dat_w,
    input logic              cpu_ack,
    input logic              mem_cyc,
    input logic              mem_stb,
    input logic              mem_we,
    input dcache_pkg::addr_t mem_adr,
    input dcache_pkg::sel_t  mem_sel,
    input dcache_pkg::data_t mem_dat_w,
    input logic              mem_ack
);

    int fail_count = 0;

    cpu_stb_cyc: assert property (@(posedge clk) disable iff (rst) cpu_stb |-> cpu_cyc)
        else begin
            fail_count++;
            $error("cpu_stb without cpu_cyc");
        end

    mem_stb_cyc: assert property (@(posedge clk) disable iff (rst) mem_stb |-> mem_cyc)
        else begin
            fail_count++;
            $error("mem_stb without mem_cyc");
        end

    cpu_hold: assert property (@(posedge clk) disable iff (rst)
        cpu_stb && !cpu_ack |=> cpu_stb && $stable(cpu_adr) && $stable(cpu_op)
                                && $stable(cpu_we) && $stable(cpu_dat_w))
        else begin
            fail_count++;
            $error("cpu request changed before ack");
        end

    mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_stb && !mem_ack |=> mem_stb && $stable(mem_adr) && $stable(mem_sel)
                                && $stable(mem_we) && $stable(mem_dat_w))
        else begin
            fail_count++;
            $error("memory request changed before ack");
        end

    ack_pulse: assert property (@(posedge clk) disable iff (rst) cpu_ack |=> !cpu_ack)
        else begin
            fail_count++;
            $error("cpu_ack longer than one cycle");
        end

    // memory traffic only while a cpu access is pending
    mem_busy: assert property (@(posedge clk) disable iff (rst) mem_cyc |-> cpu_cyc && cpu_stb)
        else begin
            fail_count++;
            $error("memory cycle without cpu request");
        end

endmodule

bind dcache_top tb_dcache_asserts u_dcache_asserts (
    .clk      (clk),
    .rst      (rst),
    .cpu_cyc  (cpu_cyc),
    .cpu_stb  (cpu_stb),
    .cpu_we   (cpu_we),
    .cpu_adr  (cpu_adr),
    .cpu_op   (cpu_op),
    .cpu_dat_w(cpu_dat_w),
    .cpu_ack  (cpu_ack),
    .mem_cyc  (mem_cyc),
    .mem_stb  (mem_stb),
    .mem_we   (mem_we),
    .mem_adr  (mem_adr),
    .mem_sel  (mem_sel),
    .mem_dat_w(mem_dat_w),
    .mem_ack  (mem_ack)
);

`default_nettype wire

//--- tb_wb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_mem (
    input  logic              clk,
    input  logic              rst,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  dcache_pkg::addr_t adr,
    input  dcache_pkg::sel_t  sel,
    input  dcache_pkg::data_t dat_w,
    output dcache_pkg::data_t dat_r,
    output logic              ack,
    output dcache_pkg::addr_t last_adr,
    output logic              last_we,
    output dcache_pkg::sel_t  last_sel,
    output dcache_pkg::data_t last_dat_w
);

    dcache_pkg::data_t mem [16384];
    dcache_pkg::data_t mmio_reg;
    integer            seed;
    int                wait_cnt;
    logic              mmio;

    function automatic dcache_pkg::data_t apply_sel(dcache_pkg::data_t old_w,
                                                    dcache_pkg::data_t new_w,
                                                    dcache_pkg::sel_t  lanes);
        dcache_pkg::data_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    // word at byte address a holds {a ^ f0f0, a}
    initial begin
        logic [15:0] a;
        seed     = 32'hc8fdd700;
        mmio_reg = 32'h12345678;
        ack      = 1'b0;
        dat_r    = '0;
        for (int i = 0; i < 16384; i++) begin
            a = 16'(i << 2);
            mem[i] = {a ^ 16'hf0f0, a};
        end
    end

    assign mmio = adr[19:16] == dcache_pkg::mmio_region;

    always @(posedge clk) begin
        if (rst) begin
            ack      <= 1'b0;
            wait_cnt <= -1;
        end else if (ack) begin
            ack <= 1'b0;
        end else if (cyc && stb) begin
            if (wait_cnt < 0) begin
                wait_cnt <= int'($unsigned($random(seed)) % 4);
            end else if (wait_cnt == 0) begin
                ack        <= 1'b1;
                wait_cnt   <= -1;
                last_adr   <= adr;
                last_we    <= we;
                last_sel   <= sel;
                last_dat_w <= dat_w;
                if (mmio) begin
                    dat_r <= mmio_reg;
                    if (we) mmio_reg <= apply_sel(mmio_reg, dat_w, sel);
                end else begin
                    dat_r <= mem[adr[15:2]];
                    if (we) mem[adr[15:2]] <= apply_sel(mem[adr[15:2]], dat_w, sel);
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- wb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module wb_bridge (
    input  logic              clk,
    input  logic              rst,
    mem_req_if.bridge         req,
    output logic              mem_cyc,
    output logic              mem_stb,
    output logic              mem_we,
    output dcache_pkg::addr_t mem_adr,
    output dcache_pkg::sel_t  mem_sel,
    output dcache_pkg::data_t mem_dat_w,
    input  dcache_pkg::data_t mem_dat_r,
    input  logic              mem_ack
);

    typedef enum logic {br_idle, br_busy} br_state_e;

    br_state_e state;
    logic      start;
    logic      finish;

    // the request is still high in the done cycle, so skip it
    assign start  = (state == br_idle) && req.req && !req.done;
    assign finish = (state == br_busy) && mem_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= br_idle;
            mem_cyc  <= 1'b0;
            mem_stb  <= 1'b0;
            mem_we   <= 1'b0;
            req.done <= 1'b0;
        end else begin
            req.done <= finish;
            if (start) begin
                state   <= br_busy;
                mem_cyc <= 1'b1;
                mem_stb <= 1'b1;
                mem_we  <= req.we;
            end else if (finish) begin
                state   <= br_idle;
                mem_cyc <= 1'b0;
                mem_stb <= 1'b0;
                mem_we  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mem_adr   <= req.adr;
            mem_sel   <= req.sel;
            mem_dat_w <= req.wdata;
        end
        if (finish) req.rdata <= mem_dat_r;
    end

endmodule

`default_nettype wire
